// File: compile.f
src/dhcp_client_pkg.sv
src/dhcp_rx_parser.sv
src/dhcp_exchange_fsm.sv
src/dhcp_frame_builder.sv
src/dhcp_client.sv
tb/dhcp_client_properties.sv
tb/dhcp_server_model.sv
tb/dhcp_client_tb.sv

// File: tb/dhcp_client_tb.sv
`timescale 1ns/1ps

module dhcp_client_tb;

import dhcp_client_pkg::*;

localparam mac_addr_t MAC      = 48'h02_1a_2b_3c_4d_5e;
localparam ipv4_t     PREF_IP  = 32'hc0a8_0164;
localparam ipv4_t     OFFER_IP = 32'hc0a8_0132;
localparam ipv4_t     SRV_IP   = 32'hc0a8_0101;
localparam ipv4_t     MASK     = 32'hffff_ff00;
localparam ipv4_t     GW_IP    = 32'hc0a8_01fe;

logic      clk = 1'b0;
logic      fsm_rst;
logic      start;
ipv4_t     preferred_ipv4;
logic      rx_sof;
logic      rx_val;
logic      rx_eof;
byte_t     rx_dat;
udp_port_t rx_src_port;
udp_port_t rx_dst_port;
logic      tx_req;
logic      tx_rdy;
byte_cnt_t tx_length;
logic      tx_sof;
logic      tx_val;
logic      tx_eof;
byte_t     tx_dat;
logic      ready;
logic      dhcp_success;
logic      dhcp_timeout;
ipv4_t     assigned_ipv4;
ipv4_t     subnet_mask;
logic      subnet_mask_val;
ipv4_t     router_ipv4_addr;
logic      router_ipv4_addr_val;
logic      model_err;
int        t0;

always #5 clk = ~clk;

dhcp_client #(
  .MAC_ADDR (MAC)
) UUT (
  .clk (clk), .fsm_rst (fsm_rst), .start (start), .preferred_ipv4 (preferred_ipv4),
  .rx_sof (rx_sof), .rx_val (rx_val), .rx_eof (rx_eof), .rx_dat (rx_dat),
  .rx_src_port (rx_src_port), .rx_dst_port (rx_dst_port), .tx_req (tx_req),
  .tx_rdy (tx_rdy), .tx_length (tx_length), .tx_sof (tx_sof), .tx_val (tx_val),
  .tx_eof (tx_eof), .tx_dat (tx_dat), .ready (ready), .dhcp_success (dhcp_success),
  .dhcp_timeout (dhcp_timeout), .assigned_ipv4 (assigned_ipv4), .subnet_mask (subnet_mask),
  .subnet_mask_val (subnet_mask_val), .router_ipv4_addr (router_ipv4_addr),
  .router_ipv4_addr_val (router_ipv4_addr_val)
);

dhcp_server_model #(
  .MAC_ADDR (MAC)
) srv (
  .clk (clk), .tx_rdy (tx_rdy), .tx_length (tx_length), .tx_sof (tx_sof),
  .tx_val (tx_val), .tx_eof (tx_eof), .tx_dat (tx_dat), .tx_req (tx_req),
  .rx_sof (rx_sof), .rx_val (rx_val), .rx_eof (rx_eof), .rx_dat (rx_dat),
  .rx_src_port (rx_src_port), .rx_dst_port (rx_dst_port), .err (model_err)
);

bind dhcp_client dhcp_client_properties u_props (
  .clk (clk), .fsm_rst (fsm_rst), .tx_req (tx_req), .tx_rdy (tx_rdy),
  .tx_val (tx_val), .tx_sof (tx_sof), .tx_eof (tx_eof), .ready (ready),
  .dhcp_success (dhcp_success), .dhcp_timeout (dhcp_timeout)
);

task automatic stop_run(input string why);
  $display("%s", why);
  $display("ERRORS FOUND");
  $fatal(1, "run stopped at first failure");
endtask

task automatic expect_val(input string name, input logic [31:0] exp, input logic [31:0] act);
  assert (act === exp) else stop_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
endtask

task automatic wait_frames(input int n);
  for (int i = 0; i < 2 * TIMEOUT_CYCLES; i++) begin
    @(posedge clk); // model counters move on the falling edge
    if (srv.frames >= n) return;
  end
  stop_run($sformatf("timed out waiting for client frame %0d", n));
endtask

task automatic wait_done();
  for (int i = 0; i < 2 * TIMEOUT_CYCLES; i++) begin
    @(negedge clk);
    if (dhcp_success || dhcp_timeout) return;
  end
  stop_run("timed out waiting for the exchange to finish");
endtask

task automatic apply_reset();
  @(negedge clk);
  fsm_rst = 1'b1;
  repeat (3) @(negedge clk);
  fsm_rst = 1'b0;
  srv.clear();
endtask

task automatic pulse_start();
  @(negedge clk);
  start = 1'b1;
  @(negedge clk);
  start = 1'b0;
endtask

always @(negedge clk) begin
  if (model_err || UUT.u_props.prop_errs != 0) begin
    stop_run("a check in the server model or a bound property failed");
  end
end

initial begin
  fsm_rst        = 1'b1;
  start          = 1'b0;
  preferred_ipv4 = PREF_IP;
  repeat (3) @(negedge clk);
  fsm_rst = 1'b0;

  //////////////////////////////
  // discover, filtering, full exchange
  //////////////////////////////
  pulse_start();
  wait_frames(1);
  srv.check_frame("discover", MSG_DISCOVER, PREF_IP, '0);
  t0 = srv.cycles;
  srv.send_reply(MSG_OFFER, ~DHCP_XID, 1'b1, OFFER_IP, SRV_IP, MASK, GW_IP, 1'b0);
  srv.send_reply(MSG_OFFER, DHCP_XID, 1'b0, OFFER_IP, SRV_IP, MASK, GW_IP, 1'b0);
  while (srv.cycles - t0 < TIMEOUT_CYCLES / 2) @(posedge clk);
  expect_val("filtered offers", 1, srv.frames);
  srv.send_reply(MSG_OFFER, DHCP_XID, 1'b1, OFFER_IP, SRV_IP, MASK, GW_IP, 1'b0);
  wait_frames(2);
  srv.check_frame("request", MSG_REQUEST, OFFER_IP, SRV_IP);
  srv.send_reply(MSG_ACK, DHCP_XID, 1'b1, OFFER_IP, SRV_IP, MASK, GW_IP, 1'b1);
  wait_done();
  expect_val("ack success", 1, dhcp_success);
  expect_val("ack ready", 1, ready);
  expect_val("ack timeout", 0, dhcp_timeout);
  expect_val("ack address", OFFER_IP, assigned_ipv4);
  expect_val("ack subnet", MASK, subnet_mask);
  expect_val("ack subnet_val", 1, subnet_mask_val);
  expect_val("ack router", GW_IP, router_ipv4_addr);
  expect_val("ack router_val", 1, router_ipv4_addr_val);

  // ack without router
  apply_reset();
  pulse_start();
  wait_frames(1);
  srv.check_frame("discover 2", MSG_DISCOVER, PREF_IP, '0);
  srv.send_reply(MSG_OFFER, DHCP_XID, 1'b1, OFFER_IP + 1, SRV_IP, MASK, GW_IP, 1'b0);
  wait_frames(2);
  srv.check_frame("request 2", MSG_REQUEST, OFFER_IP + 1, SRV_IP);
  srv.send_reply(MSG_ACK, DHCP_XID, 1'b1, OFFER_IP + 1, SRV_IP, MASK, GW_IP, 1'b0);
  wait_done();
  expect_val("no router success", 1, dhcp_success);
  expect_val("no router address", OFFER_IP + 1, assigned_ipv4);
  expect_val("no router subnet_val", 1, subnet_mask_val);
  expect_val("no router router_val", 0, router_ipv4_addr_val);

  //////////////////////////////
  // retries and fallback with a silent server
  //////////////////////////////
  apply_reset();
  pulse_start();
  for (int i = 1; i <= RETRIES + 1; i++) begin
    wait_frames(i);
    srv.check_frame($sformatf("retry discover %0d", i), MSG_DISCOVER, PREF_IP, '0);
  end
  wait_done();
  expect_val("discover count", RETRIES + 1, srv.frames);
  expect_val("fallback timeout", 1, dhcp_timeout);
  expect_val("fallback ready", 1, ready);
  expect_val("fallback success", 0, dhcp_success);
  expect_val("fallback address", PREF_IP, assigned_ipv4);

  @(negedge clk);
  if (model_err || UUT.u_props.prop_errs != 0) begin
    stop_run("a check failed at the end of the run");
  end else begin
    $display("NO ERRORS");
    $finish;
  end
end

endmodule

// File: tb/dhcp_server_model.sv
`timescale 1ns/1ps

module dhcp_server_model #(
  parameter dhcp_client_pkg::mac_addr_t MAC_ADDR = 48'h02_00_00_00_00_01
) (
  input  logic                       clk,
  input  logic                       tx_rdy,
  input  dhcp_client_pkg::byte_cnt_t tx_length,
  input  logic                       tx_sof,
  input  logic                       tx_val,
  input  logic                       tx_eof,
  input  dhcp_client_pkg::byte_t     tx_dat,
  output logic                       tx_req,
  output logic                       rx_sof,
  output logic                       rx_val,
  output logic                       rx_eof,
  output dhcp_client_pkg::byte_t     rx_dat,
  output dhcp_client_pkg::udp_port_t rx_src_port,
  output dhcp_client_pkg::udp_port_t rx_dst_port,
  output logic                       err
);

import dhcp_client_pkg::*;

integer    seed = 22270;
int        frames = 0;   // complete client frames
int        cycles = 0;
int        cap_idx = 0;
int        cap_len = 0;
byte_cnt_t cap_tx_len;
byte_t     cap [0:299];
byte_t     work [0:299]; // expected frame or outgoing reply
int        wp;

initial begin
  tx_req      = 1'b0;
  rx_sof      = 1'b0;
  rx_val      = 1'b0;
  rx_eof      = 1'b0;
  rx_dat      = '0;
  rx_src_port = '0;
  rx_dst_port = '0;
  err         = 1'b0;
end

// capture client frames and drive tx_req with random gaps
always @(negedge clk) begin
  cycles++;
  if (tx_val) begin
    if (tx_sof) begin
      cap_idx    = 0;
      cap_tx_len = tx_length;
    end
    if (cap_idx < 300) cap[cap_idx] = tx_dat;
    cap_idx++;
    if (tx_eof) begin
      cap_len = cap_idx;
      frames++;
    end
  end
  tx_req = tx_rdy && (($random(seed) & 3) != 0);
end

task automatic clear();
  frames  = 0;
  cap_idx = 0;
  cap_len = 0;
endtask

task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
  if (err) return;
  assert (act === exp) else begin
    $display("mismatch %s expected %h actual %h", name, exp, act);
    err = 1'b1;
  end
endtask

task automatic clear_work();
  for (int i = 0; i < 300; i++) work[i] = '0;
  wp = 0;
endtask

task automatic put(input byte_t b);
  work[wp] = b;
  wp++;
endtask

task automatic put_ip(input logic [31:0] v);
  for (int k = 0; k < 4; k++) put(v[31 - 8 * k -: 8]);
endtask

task automatic check_frame(input string name, input msg_type_t kind, input ipv4_t req_ip,
                           input ipv4_t srv_id);
  byte_cnt_t opt_len;
  opt_len = (kind == MSG_REQUEST) ? REQUEST_OPT_LEN : DISCOVER_OPT_LEN;
  clear_work();
  work[0] = BOOT_REQUEST;
  work[1] = 8'd1;
  work[2] = 8'd6;
  wp = 4;
  put_ip(DHCP_XID);
  work[10] = 8'h80; // broadcast
  for (int i = 0; i < 6; i++) work[28 + i] = MAC_ADDR[47 - 8 * i -: 8];
  wp = 236;
  put_ip(DHCP_COOKIE);
  put(OPT_MSG_TYPE);
  put(8'd1);
  put(kind);
  put(OPT_REQ_IP);
  put(8'd4);
  put_ip(req_ip);
  put(OPT_CLIENT_ID);
  put(8'd7);
  put(8'd1);
  for (int i = 0; i < 6; i++) put(MAC_ADDR[47 - 8 * i -: 8]);
  if (kind == MSG_REQUEST) begin
    put(OPT_SERVER_ID);
    put(8'd4);
    put_ip(srv_id);
  end
  put(OPT_END);
  check_val({name, " length"}, HDR_LEN + opt_len, cap_len);
  check_val({name, " tx_length"}, UDP_HDR_LEN + HDR_LEN + opt_len, cap_tx_len);
  for (int i = 0; i < wp; i++) check_val($sformatf("%s byte %0d", name, i), work[i], cap[i]);
endtask

task automatic send_reply(input msg_type_t kind, input xid_t xid, input logic good_ports,
                          input ipv4_t yiaddr, input ipv4_t srv_id, input ipv4_t subnet,
                          input ipv4_t router, input logic with_router);
  int len;
  clear_work();
  work[0] = BOOT_REPLY;
  work[1] = 8'd1;
  work[2] = 8'd6;
  wp = 4;
  put_ip(xid);
  wp = 16;
  put_ip(yiaddr);
  wp = 236;
  put_ip(DHCP_COOKIE);
  put(OPT_MSG_TYPE);
  put(8'd1);
  put(kind);
  put(OPT_SERVER_ID);
  put(8'd4);
  put_ip(srv_id);
  if (kind == MSG_ACK) begin
    put(OPT_SUBNET_MASK);
    put(8'd4);
    put_ip(subnet);
    put(8'd51); // lease time is skipped by length
    put(8'd4);
    put_ip(32'd3600);
    put(OPT_PAD);
    if (with_router) begin
      put(OPT_ROUTER);
      put(8'd4);
      put_ip(router);
    end
  end
  put(OPT_END);
  len = wp;
  for (int i = 0; i < len; i++) begin
    @(negedge clk);
    if (i == 0) begin
      rx_src_port = good_ports ? DHCP_SRV_PORT : DHCP_CLI_PORT;
      rx_dst_port = good_ports ? DHCP_CLI_PORT : DHCP_SRV_PORT;
    end
    rx_val = 1'b1;
    rx_sof = (i == 0);
    rx_eof = (i == len - 1);
    rx_dat = work[i];
  end
  @(negedge clk);
  rx_val = 1'b0;
  rx_sof = 1'b0;
  rx_eof = 1'b0;
endtask

endmodule

// File: tb/dhcp_client_properties.sv
`timescale 1ns/1ps

module dhcp_client_properties (
  input logic clk,
  input logic fsm_rst,
  input logic tx_req,
  input logic tx_rdy,
  input logic tx_val,
  input logic tx_sof,
  input logic tx_eof,
  input logic ready,
  input logic dhcp_success,
  input logic dhcp_timeout
);

int prop_errs = 0; // read by the testbench top

//////////////////////////////
// transmit stream
//////////////////////////////
val_after_req: assert property (@(posedge clk) disable iff (fsm_rst) tx_val |-> $past(tx_req))
  else begin
    $error("tx_val without tx_req in the previous cycle");
    prop_errs++;
  end

marks_with_val: assert property (@(posedge clk) disable iff (fsm_rst)
  (tx_sof || tx_eof) |-> tx_val)
  else begin
    $error("tx_sof or tx_eof without tx_val");
    prop_errs++;
  end

//////////////////////////////
// status
//////////////////////////////
reset_state: assert property (@(posedge clk)
  $past(fsm_rst) |-> !tx_rdy && !tx_val && !ready && !dhcp_success && !dhcp_timeout)
  else begin
    $error("outputs not cleared by reset");
    prop_errs++;
  end

one_result: assert property (@(posedge clk) disable iff (fsm_rst) !(dhcp_success && dhcp_timeout))
  else begin
    $error("dhcp_success and dhcp_timeout both high");
    prop_errs++;
  end

ready_holds: assert property (@(posedge clk) $fell(ready) |-> $past(fsm_rst))
  else begin
    $error("ready fell without reset");
    prop_errs++;
  end

endmodule

// File: src/dhcp_client.sv
`timescale 1ns/1ps

module dhcp_client #(
  parameter dhcp_client_pkg::mac_addr_t MAC_ADDR = 48'h02_00_00_00_00_01
) (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  logic                       start,
  input  dhcp_client_pkg::ipv4_t     preferred_ipv4,
  input  logic                       rx_sof,
  input  logic                       rx_val,
  input  logic                       rx_eof,
  input  dhcp_client_pkg::byte_t     rx_dat,
  input  dhcp_client_pkg::udp_port_t rx_src_port,
  input  dhcp_client_pkg::udp_port_t rx_dst_port,
  input  logic                       tx_req,
  output logic                       tx_rdy,
  output dhcp_client_pkg::byte_cnt_t tx_length,
  output logic                       tx_sof,
  output logic                       tx_val,
  output logic                       tx_eof,
  output dhcp_client_pkg::byte_t     tx_dat,
  output logic                       ready,
  output logic                       dhcp_success,
  output logic                       dhcp_timeout,
  output dhcp_client_pkg::ipv4_t     assigned_ipv4,
  output dhcp_client_pkg::ipv4_t     subnet_mask,
  output logic                       subnet_mask_val,
  output dhcp_client_pkg::ipv4_t     router_ipv4_addr,
  output logic                       router_ipv4_addr_val
);

import dhcp_client_pkg::*;

// parser to controller
logic      reply_val;
msg_type_t reply_type;
ipv4_t     reply_yiaddr;
ipv4_t     reply_server_id;
ipv4_t     reply_subnet;
logic      reply_subnet_pres;
ipv4_t     reply_router;
logic      reply_router_pres;

// controller to builder
logic      send;
msg_type_t send_type;
ipv4_t     send_req_ip;
ipv4_t     send_server_id;

dhcp_rx_parser u_rx_parser (
  .clk               (clk),
  .fsm_rst           (fsm_rst),
  .rx_sof            (rx_sof),
  .rx_val            (rx_val),
  .rx_eof            (rx_eof),
  .rx_dat            (rx_dat),
  .rx_src_port       (rx_src_port),
  .rx_dst_port       (rx_dst_port),
  .reply_val         (reply_val),
  .reply_type        (reply_type),
  .reply_yiaddr      (reply_yiaddr),
  .reply_server_id   (reply_server_id),
  .reply_subnet      (reply_subnet),
  .reply_subnet_pres (reply_subnet_pres),
  .reply_router      (reply_router),
  .reply_router_pres (reply_router_pres)
);

dhcp_exchange_fsm u_exchange_fsm (
  .clk                  (clk),
  .fsm_rst              (fsm_rst),
  .start                (start),
  .preferred_ipv4       (preferred_ipv4),
  .tx_rdy               (tx_rdy),
  .reply_val            (reply_val),
  .reply_type           (reply_type),
  .reply_yiaddr         (reply_yiaddr),
  .reply_server_id      (reply_server_id),
  .reply_subnet         (reply_subnet),
  .reply_subnet_pres    (reply_subnet_pres),
  .reply_router         (reply_router),
  .reply_router_pres    (reply_router_pres),
  .send                 (send),
  .send_type            (send_type),
  .send_req_ip          (send_req_ip),
  .send_server_id       (send_server_id),
  .ready                (ready),
  .dhcp_success         (dhcp_success),
  .dhcp_timeout         (dhcp_timeout),
  .assigned_ipv4        (assigned_ipv4),
  .subnet_mask          (subnet_mask),
  .subnet_mask_val      (subnet_mask_val),
  .router_ipv4_addr     (router_ipv4_addr),
  .router_ipv4_addr_val (router_ipv4_addr_val)
);

dhcp_frame_builder #(
  .MAC_ADDR (MAC_ADDR)
) u_frame_builder (
  .clk            (clk),
  .fsm_rst        (fsm_rst),
  .send           (send),
  .send_type      (send_type),
  .send_req_ip    (send_req_ip),
  .send_server_id (send_server_id),
  .tx_req         (tx_req),
  .tx_rdy         (tx_rdy),
  .tx_length      (tx_length),
  .tx_sof         (tx_sof),
  .tx_val         (tx_val),
  .tx_eof         (tx_eof),
  .tx_dat         (tx_dat)
);

endmodule

// File: src/dhcp_frame_builder.sv
`timescale 1ns/1ps

module dhcp_frame_builder #(
  parameter dhcp_client_pkg::mac_addr_t MAC_ADDR = 48'h02_00_00_00_00_01
) (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  logic                       send,
  input  dhcp_client_pkg::msg_type_t send_type,
  input  dhcp_client_pkg::ipv4_t     send_req_ip,
  input  dhcp_client_pkg::ipv4_t     send_server_id,
  input  logic                       tx_req,
  output logic                       tx_rdy,
  output dhcp_client_pkg::byte_cnt_t tx_length,
  output logic                       tx_sof,
  output logic                       tx_val,
  output logic                       tx_eof,
  output dhcp_client_pkg::byte_t     tx_dat
);

import dhcp_client_pkg::*;

msg_type_t msg_type;
ipv4_t     req_ip;
ipv4_t     server_id;
logic      is_req;
byte_cnt_t frame_len;
byte_cnt_t pos;       // bytes already presented
byte_cnt_t opt_pos;
logic      present;
byte_t     next_byte;

assign is_req    = (msg_type == MSG_REQUEST);
assign frame_len = HDR_LEN + (is_req ? REQUEST_OPT_LEN : DISCOVER_OPT_LEN);
assign tx_length = UDP_HDR_LEN + frame_len;
assign opt_pos   = pos - HDR_LEN;
assign present   = tx_rdy && tx_req && (pos != frame_len);

//////////////////////////////
// byte select
//////////////////////////////
always_comb begin
  next_byte = '0; // unused header fields are zero
  if (pos == 16'd0) next_byte = BOOT_REQUEST;
  else if (pos == 16'd1) next_byte = 8'd1; // htype ethernet
  else if (pos == 16'd2) next_byte = 8'd6; // hlen
  else if (pos >= 16'd4 && pos <= 16'd7) next_byte = DHCP_XID[8 * (7 - pos) +: 8];
  else if (pos == 16'd10) next_byte = 8'h80; // broadcast flag
  else if (pos >= 16'd28 && pos <= 16'd33) next_byte = MAC_ADDR[8 * (33 - pos) +: 8];
  else if (pos >= HDR_LEN - 16'd4 && pos < HDR_LEN) begin
    next_byte = DHCP_COOKIE[8 * (HDR_LEN - 16'd1 - pos) +: 8];
  end else if (pos >= HDR_LEN) begin
    case (opt_pos)
      0:              next_byte = OPT_MSG_TYPE;
      1:              next_byte = 8'd1;
      2:              next_byte = msg_type;
      3:              next_byte = OPT_REQ_IP;
      4:              next_byte = 8'd4;
      5, 6, 7, 8:     next_byte = req_ip[8 * (8 - opt_pos) +: 8];
      9:              next_byte = OPT_CLIENT_ID;
      10:             next_byte = 8'd7;
      11:             next_byte = 8'd1; // id type, then the mac
      12, 13, 14, 15,
      16, 17:         next_byte = MAC_ADDR[8 * (17 - opt_pos) +: 8];
      18:             next_byte = is_req ? OPT_SERVER_ID : OPT_END;
      19:             next_byte = 8'd4;
      20, 21, 22, 23: next_byte = server_id[8 * (23 - opt_pos) +: 8];
      24:             next_byte = OPT_END;
      default:        next_byte = '0;
    endcase
  end
end

always_ff @(posedge clk) begin
  if (fsm_rst) begin
    tx_rdy <= 1'b0;
    tx_val <= 1'b0;
    tx_sof <= 1'b0;
    tx_eof <= 1'b0;
    pos    <= '0;
  end else begin
    tx_val <= 1'b0;
    tx_sof <= 1'b0;
    tx_eof <= 1'b0;
    if (send) begin
      tx_rdy <= 1'b1;
      pos    <= '0;
    end else if (tx_val && tx_eof) tx_rdy <= 1'b0;
    if (present) begin
      tx_val <= 1'b1;
      tx_sof <= (pos == 16'd0);
      tx_eof <= (pos == frame_len - 16'd1);
      pos    <= pos + 16'd1;
    end
  end
end

always_ff @(posedge clk) begin
  if (send) begin
    msg_type  <= send_type;
    req_ip    <= send_req_ip;
    server_id <= send_server_id;
  end
  if (present) tx_dat <= next_byte;
end

endmodule

// File: src/dhcp_exchange_fsm.sv
`timescale 1ns/1ps

module dhcp_exchange_fsm (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  logic                       start,
  input  dhcp_client_pkg::ipv4_t     preferred_ipv4,
  input  logic                       tx_rdy,
  input  logic                       reply_val,
  input  dhcp_client_pkg::msg_type_t reply_type,
  input  dhcp_client_pkg::ipv4_t     reply_yiaddr,
  input  dhcp_client_pkg::ipv4_t     reply_server_id,
  input  dhcp_client_pkg::ipv4_t     reply_subnet,
  input  logic                       reply_subnet_pres,
  input  dhcp_client_pkg::ipv4_t     reply_router,
  input  logic                       reply_router_pres,
  output logic                       send,
  output dhcp_client_pkg::msg_type_t send_type,
  output dhcp_client_pkg::ipv4_t     send_req_ip,
  output dhcp_client_pkg::ipv4_t     send_server_id,
  output logic                       ready,
  output logic                       dhcp_success,
  output logic                       dhcp_timeout,
  output dhcp_client_pkg::ipv4_t     assigned_ipv4,
  output dhcp_client_pkg::ipv4_t     subnet_mask,
  output logic                       subnet_mask_val,
  output dhcp_client_pkg::ipv4_t     router_ipv4_addr,
  output logic                       router_ipv4_addr_val
);

import dhcp_client_pkg::*;

exch_state_t                       state;
logic [$clog2(TIMEOUT_CYCLES)-1:0] wait_cnt;
logic [$clog2(RETRIES+1)-1:0]      tries;
ipv4_t                             offered_ip;
ipv4_t                             server_id;
logic                              waiting;
logic                              expired;
logic                              give_up;
logic                              offer_ok;
logic                              ack_ok;

assign waiting  = (state == offer_s) || (state == ack_s);
assign expired  = waiting && (wait_cnt == TIMEOUT_CYCLES - 1);
assign give_up  = expired && (tries == RETRIES); // initial discover plus RETRIES resends
assign offer_ok = (state == offer_s) && reply_val && (reply_type == MSG_OFFER);
assign ack_ok   = (state == ack_s) && reply_val && (reply_type == MSG_ACK);

// hold off while the builder still owns a frame
assign send           = ((state == discover_s) || (state == request_s)) && !tx_rdy;
assign send_type      = (state == request_s) ? MSG_REQUEST : MSG_DISCOVER;
assign send_req_ip    = (state == request_s) ? offered_ip : preferred_ipv4;
assign send_server_id = server_id;

always_ff @(posedge clk) begin
  if (fsm_rst) begin
    state                <= idle_s;
    wait_cnt             <= '0;
    tries                <= '0;
    ready                <= 1'b0;
    dhcp_success         <= 1'b0;
    dhcp_timeout         <= 1'b0;
    subnet_mask_val      <= 1'b0;
    router_ipv4_addr_val <= 1'b0;
  end else begin
    wait_cnt <= waiting ? wait_cnt + 1'b1 : '0;
    case (state)
      idle_s:     if (start) state <= discover_s;
      discover_s: if (send) state <= offer_s;
      request_s:  if (send) state <= ack_s;
      offer_s, ack_s: begin
        if (ack_ok) begin
          state        <= bound_s;
          dhcp_success <= 1'b1;
          ready        <= 1'b1;
          if (reply_subnet_pres) subnet_mask_val <= 1'b1;
          if (reply_router_pres) router_ipv4_addr_val <= 1'b1;
        end else if (offer_ok) begin
          state <= request_s;
        end else if (give_up) begin
          state        <= failed_s;
          dhcp_timeout <= 1'b1;
          ready        <= 1'b1;
        end else if (expired) begin
          tries <= tries + 1'b1;
          state <= discover_s; // start over from discover
        end
      end
      default: state <= state; // bound and failed are final
    endcase
  end
end

always_ff @(posedge clk) begin
  if (offer_ok) begin
    offered_ip <= reply_yiaddr;
    server_id  <= reply_server_id;
  end
  if (ack_ok) assigned_ipv4 <= reply_yiaddr;
  else if (give_up) assigned_ipv4 <= preferred_ipv4; // fallback address
  if (ack_ok && reply_subnet_pres) subnet_mask <= reply_subnet;
  if (ack_ok && reply_router_pres) router_ipv4_addr <= reply_router;
end

endmodule

// File: src/dhcp_rx_parser.sv
`timescale 1ns/1ps

module dhcp_rx_parser (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  logic                       rx_sof,
  input  logic                       rx_val,
  input  logic                       rx_eof,
  input  dhcp_client_pkg::byte_t     rx_dat,
  input  dhcp_client_pkg::udp_port_t rx_src_port,
  input  dhcp_client_pkg::udp_port_t rx_dst_port,
  output logic                       reply_val,
  output dhcp_client_pkg::msg_type_t reply_type,
  output dhcp_client_pkg::ipv4_t     reply_yiaddr,
  output dhcp_client_pkg::ipv4_t     reply_server_id,
  output dhcp_client_pkg::ipv4_t     reply_subnet,
  output logic                       reply_subnet_pres,
  output dhcp_client_pkg::ipv4_t     reply_router,
  output logic                       reply_router_pres
);

import dhcp_client_pkg::*;

byte_cnt_t   byte_cnt;
byte_cnt_t   idx;        // offset of the byte on rx_dat
logic        frame_good; // ports matched at sof
byte_t       op;
xid_t        xid;
logic [31:0] cookie;

enum logic [1:0] {kind_f, len_f, data_f, done_f} opt_field;
byte_t opt_kind;
byte_t opt_len;
byte_t opt_cnt;
ipv4_t opt_data;
logic  opt_en;
logic  opt_last;
logic  end_seen;

assign idx      = rx_sof ? '0 : byte_cnt;
assign opt_en   = rx_val && frame_good && (idx >= HDR_LEN);
assign opt_last = opt_en && (opt_field == data_f) && (opt_cnt == opt_len - 8'd1);
assign end_seen = opt_en && (opt_field == kind_f) && (rx_dat == OPT_END);

always_ff @(posedge clk) begin
  if (fsm_rst) begin
    byte_cnt          <= '0;
    frame_good        <= 1'b0;
    opt_field         <= kind_f;
    opt_kind          <= '0;
    opt_len           <= '0;
    opt_cnt           <= '0;
    reply_val         <= 1'b0;
    reply_subnet_pres <= 1'b0;
    reply_router_pres <= 1'b0;
  end else begin
    reply_val <= end_seen && (op == BOOT_REPLY) && (xid == DHCP_XID) && (cookie == DHCP_COOKIE);
    if (rx_val) byte_cnt <= idx + 16'd1;
    if (rx_val && rx_sof) begin
      frame_good        <= (rx_src_port == DHCP_SRV_PORT) && (rx_dst_port == DHCP_CLI_PORT);
      reply_subnet_pres <= 1'b0;
      reply_router_pres <= 1'b0;
    end
    //////////////////////////////
    // option walker
    //////////////////////////////
    if (opt_en) begin
      case (opt_field)
        kind_f: begin
          opt_kind <= rx_dat;
          opt_cnt  <= '0;
          if (rx_dat == OPT_END) opt_field <= done_f;
          else if (rx_dat != OPT_PAD) opt_field <= len_f; // pad has no length byte
        end
        len_f: begin
          opt_len   <= rx_dat;
          opt_field <= (rx_dat == 8'd0) ? kind_f : data_f;
        end
        data_f: begin
          opt_cnt <= opt_cnt + 8'd1;
          if (opt_last) opt_field <= kind_f;
        end
        default: opt_field <= done_f; // ignore trailing bytes
      endcase
    end
    if (opt_last && opt_kind == OPT_SUBNET_MASK) reply_subnet_pres <= 1'b1;
    if (opt_last && opt_kind == OPT_ROUTER) reply_router_pres <= 1'b1;
    if (rx_val && rx_eof) begin
      byte_cnt   <= '0;
      frame_good <= 1'b0;
      opt_field  <= kind_f;
    end
  end
end

// header fields and option payloads
always_ff @(posedge clk) begin
  if (rx_val) begin
    if (idx == 16'd0) op <= rx_dat;
    if (idx >= 16'd4 && idx <= 16'd7) xid <= {xid[23:0], rx_dat};
    if (idx >= 16'd16 && idx <= 16'd19) reply_yiaddr <= {reply_yiaddr[23:0], rx_dat};
    if (idx >= HDR_LEN - 16'd4 && idx < HDR_LEN) cookie <= {cookie[23:0], rx_dat};
    if (rx_sof) reply_type <= '0;
  end
  if (opt_en && opt_field == data_f) opt_data <= {opt_data[23:0], rx_dat};
  if (opt_last) begin
    case (opt_kind)
      OPT_MSG_TYPE:    reply_type      <= rx_dat;
      OPT_SUBNET_MASK: reply_subnet    <= {opt_data[23:0], rx_dat};
      OPT_ROUTER:      reply_router    <= {opt_data[23:0], rx_dat}; // last listed router wins
      OPT_SERVER_ID:   reply_server_id <= {opt_data[23:0], rx_dat};
      default: ;
    endcase
  end
end

endmodule

// File: src/dhcp_client_pkg.sv
package dhcp_client_pkg;

typedef logic [7:0]  byte_t;
typedef logic [31:0] ipv4_t;      // msb goes out first
typedef logic [47:0] mac_addr_t;
typedef logic [31:0] xid_t;
typedef logic [15:0] udp_port_t;
typedef logic [15:0] byte_cnt_t;
typedef logic [7:0]  msg_type_t;

typedef enum logic [2:0] {
  idle_s,
  discover_s,
  offer_s,
  request_s,
  ack_s,
  bound_s,
  failed_s
} exch_state_t;

localparam udp_port_t DHCP_CLI_PORT = 16'd68;
localparam udp_port_t DHCP_SRV_PORT = 16'd67;

localparam byte_t BOOT_REQUEST = 8'd1;
localparam byte_t BOOT_REPLY   = 8'd2;

localparam msg_type_t MSG_DISCOVER = 8'd1;
localparam msg_type_t MSG_OFFER    = 8'd2;
localparam msg_type_t MSG_REQUEST  = 8'd3;
localparam msg_type_t MSG_ACK      = 8'd5;

//////////////////////////////
// option codes
//////////////////////////////
localparam byte_t OPT_PAD         = 8'd0;
localparam byte_t OPT_SUBNET_MASK = 8'd1;
localparam byte_t OPT_ROUTER      = 8'd3;
localparam byte_t OPT_REQ_IP      = 8'd50;
localparam byte_t OPT_MSG_TYPE    = 8'd53;
localparam byte_t OPT_SERVER_ID   = 8'd54;
localparam byte_t OPT_CLIENT_ID   = 8'd61;
localparam byte_t OPT_END         = 8'd255;

localparam xid_t        DHCP_XID    = 32'h5a17_c0de;
localparam logic [31:0] DHCP_COOKIE = 32'h6382_5363;

localparam byte_cnt_t HDR_LEN          = 16'd240; // bootp header + cookie
localparam byte_cnt_t UDP_HDR_LEN      = 16'd8;
localparam byte_cnt_t DISCOVER_OPT_LEN = 16'd19;
localparam byte_cnt_t REQUEST_OPT_LEN  = 16'd25;  // discover plus server id

localparam int TIMEOUT_CYCLES = 2000; // per reply
localparam int RETRIES        = 3;

endpackage
